/* src/rv_pipe_pkg.sv */
// ----------------------------------------------------------
// Integer pipeline package. Register-file sizes, RV32I opcodes,
// ALU operations and the records passed between stages
// ----------------------------------------------------------
`default_nettype none

package rv_pipe_pkg;

  // ----------------------------------------------------------
  // Register file geometry
  // ----------------------------------------------------------
  parameter int unsigned REGFILE_NUM_WORDS       = 32;
  parameter int unsigned REGFILE_WORD_WIDTH      = 32;
  // Port 0 is writeback, port 1 is the external load port
  parameter int unsigned REGFILE_NUM_WRITE_PORTS = 2;
  parameter int unsigned REGFILE_ADDR_WIDTH      = $clog2(REGFILE_NUM_WORDS);

  typedef logic [REGFILE_ADDR_WIDTH-1:0] rf_addr_t;
  typedef logic [REGFILE_WORD_WIDTH-1:0] rf_word_t;

  // ----------------------------------------------------------
  // Major opcodes handled by this slice
  // ----------------------------------------------------------
  parameter logic [6:0] OPC_OP     = 7'b0110011;
  parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
  parameter logic [6:0] OPC_LUI    = 7'b0110111;

  // ALU operations, LUI just forwards operand b
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_LUI
  } alu_op_e;

  // ----------------------------------------------------------
  // Stage records
  // ----------------------------------------------------------
  // Decode to execute, operand b already holds any immediate
  typedef struct packed {
    logic     valid;
    logic     illegal;
    logic     wen;
    rf_addr_t rd;
    alu_op_e  op;
    rf_word_t opa;
    rf_word_t opb;
  } dec_op_t;

  // Bypass source, only valid for writes to x1..x31
  typedef struct packed {
    logic     valid;
    rf_addr_t rd;
    rf_word_t value;
  } fwd_t;

  // Executed result, also the retire record
  typedef struct packed {
    logic     valid;
    logic     illegal;
    logic     wen;
    rf_addr_t rd;
    rf_word_t result;
  } exe_res_t;

endpackage

`default_nettype wire

/* src/rv_register_file.sv */
// ----------------------------------------------------------
// Flip-flop register file with combinational read ports and
// prioritized write ports, the highest-numbered port wins
// ----------------------------------------------------------
`default_nettype none

module rv_register_file import rv_pipe_pkg::*; #(
  parameter int unsigned NUM_READ_PORTS = 2
) (
  input  logic     clk,
  input  logic     rst_n,

  // Read ports
  input  rf_addr_t raddr_i [NUM_READ_PORTS],
  output rf_word_t rdata_o [NUM_READ_PORTS],

  // Write ports
  input  rf_addr_t waddr_i [REGFILE_NUM_WRITE_PORTS],
  input  rf_word_t wdata_i [REGFILE_NUM_WRITE_PORTS],
  input  logic     we_i    [REGFILE_NUM_WRITE_PORTS]
);

  // Storage array
  rf_word_t mem [REGFILE_NUM_WORDS];

  // One enable per port and register
  logic [REGFILE_NUM_WORDS-1:0] we_dec [REGFILE_NUM_WRITE_PORTS];

  // ----------------------------------------------------------
  // Read multiplexers
  // ----------------------------------------------------------
  for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : gen_read
    assign rdata_o[p] = mem[raddr_i[p]];
  end

  // ----------------------------------------------------------
  // Write-enable decoder
  // ----------------------------------------------------------
  for (genvar w = 0; w < REGFILE_NUM_WRITE_PORTS; w++) begin : gen_wdec
    for (genvar r = 0; r < REGFILE_NUM_WORDS; r++) begin : gen_word
      assign we_dec[w][r] = we_i[w] && (waddr_i[w] == rf_addr_t'(r));
    end
  end

  // ----------------------------------------------------------
  // Register array
  // ----------------------------------------------------------
  for (genvar r = 0; r < REGFILE_NUM_WORDS; r++) begin : gen_reg
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        mem[r] <= '0;
      end else begin
        // Later ports override earlier ones
        for (int w = 0; w < REGFILE_NUM_WRITE_PORTS; w++) begin
          if (we_dec[w][r]) begin
            mem[r] <= wdata_i[w];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/rv_decode.sv */
// ----------------------------------------------------------
// RV32I decoder with operand read, bypass selection and the
// decode-to-execute pipeline register
// ----------------------------------------------------------
`default_nettype none

module rv_decode import rv_pipe_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  output rf_addr_t    rf_raddr_o [2],
  input  rf_word_t    rf_rdata_i [2],
  input  fwd_t        fwd_early_i,
  input  fwd_t        fwd_late_i,
  output dec_op_t     dec_o
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rf_addr_t   rd;
  rf_word_t   imm_i;
  rf_word_t   imm_u;

  alu_op_e  op;
  logic     illegal;
  logic     use_imm;
  logic     is_lui;
  rf_word_t rs1_val;
  rf_word_t rs2_val;
  dec_op_t  dec_d;
  dec_op_t  dec_q;

  // Priority: x0, early bypass, late bypass, register file
  function automatic rf_word_t pick_operand(rf_addr_t rs, rf_word_t rf_val,
                                            fwd_t early, fwd_t late);
    rf_word_t val;
    if (rs == '0) val = '0;
    else if (early.valid && early.rd == rs) val = early.value;
    else if (late.valid && late.rd == rs) val = late.value;
    else val = rf_val;
    return val;
  endfunction

  assign opcode        = instr_i[6:0];
  assign rd            = instr_i[11:7];
  assign funct3        = instr_i[14:12];
  assign funct7        = instr_i[31:25];
  assign rf_raddr_o[0] = instr_i[19:15];
  assign rf_raddr_o[1] = instr_i[24:20];

  // Sign-extended I immediate and upper U immediate
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u = {instr_i[31:12], 12'b0};

  // ----------------------------------------------------------
  // Opcode, funct3 and funct7 decode
  // ----------------------------------------------------------
  always_comb begin
    op      = ALU_ADD;
    illegal = 1'b0;
    use_imm = 1'b0;
    is_lui  = 1'b0;
    case (opcode)
      OPC_OP: begin
        case ({funct7, funct3})
          10'b0000000_000: op = ALU_ADD;
          10'b0100000_000: op = ALU_SUB;
          10'b0000000_001: op = ALU_SLL;
          10'b0000000_010: op = ALU_SLT;
          10'b0000000_011: op = ALU_SLTU;
          10'b0000000_100: op = ALU_XOR;
          10'b0000000_101: op = ALU_SRL;
          10'b0100000_101: op = ALU_SRA;
          10'b0000000_110: op = ALU_OR;
          10'b0000000_111: op = ALU_AND;
          default:         illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          3'b000: op = ALU_ADD;
          3'b010: op = ALU_SLT;
          3'b011: op = ALU_SLTU;
          3'b100: op = ALU_XOR;
          3'b110: op = ALU_OR;
          3'b111: op = ALU_AND;
          // Shift immediates constrain the upper seven bits
          3'b001: begin
            op      = ALU_SLL;
            illegal = (funct7 != 7'b0000000);
          end
          default: begin
            op      = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end
      OPC_LUI: begin
        op     = ALU_LUI;
        is_lui = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

  assign rs1_val = pick_operand(rf_raddr_o[0], rf_rdata_i[0], fwd_early_i, fwd_late_i);
  assign rs2_val = pick_operand(rf_raddr_o[1], rf_rdata_i[1], fwd_early_i, fwd_late_i);

  // Next stage record, no write for illegal ops or rd of x0
  always_comb begin
    dec_d.valid   = instr_valid_i;
    dec_d.illegal = illegal;
    dec_d.wen     = !illegal && (rd != '0);
    dec_d.rd      = rd;
    dec_d.op      = op;
    dec_d.opa     = rs1_val;
    if (is_lui) dec_d.opb = imm_u;
    else if (use_imm) dec_d.opb = imm_i;
    else dec_d.opb = rs2_val;
  end

  // ----------------------------------------------------------
  // Decode-to-execute register
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_q <= '0;
    end else begin
      dec_q <= dec_d;
    end
  end

  assign dec_o = dec_q;

endmodule

`default_nettype wire

/* src/rv_execute.sv */
// ----------------------------------------------------------
// Combinational ALU, turns a decoded operation into a result
// ----------------------------------------------------------
`default_nettype none

module rv_execute import rv_pipe_pkg::*; (
  input  dec_op_t  dec_i,
  output exe_res_t res_o
);

  rf_word_t   result;
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Shifts only look at the low five bits of operand b
  assign shamt = dec_i.opb[4:0];

  // Compares shared by SLT and SLTU
  assign lt_signed   = $signed(dec_i.opa) < $signed(dec_i.opb);
  assign lt_unsigned = dec_i.opa < dec_i.opb;

  // ----------------------------------------------------------
  // Operation select
  // ----------------------------------------------------------
  always_comb begin
    result = '0;
    if (!dec_i.illegal) begin
      case (dec_i.op)
        ALU_ADD:  result = dec_i.opa + dec_i.opb;
        ALU_SUB:  result = dec_i.opa - dec_i.opb;
        ALU_SLL:  result = dec_i.opa << shamt;
        ALU_SLT:  result = {{(REGFILE_WORD_WIDTH-1){1'b0}}, lt_signed};
        ALU_SLTU: result = {{(REGFILE_WORD_WIDTH-1){1'b0}}, lt_unsigned};
        ALU_XOR:  result = dec_i.opa ^ dec_i.opb;
        ALU_SRL:  result = dec_i.opa >> shamt;
        // Arithmetic shift keeps the sign bit
        ALU_SRA:  result = rf_word_t'($signed(dec_i.opa) >>> shamt);
        ALU_OR:   result = dec_i.opa | dec_i.opb;
        ALU_AND:  result = dec_i.opa & dec_i.opb;
        ALU_LUI:  result = dec_i.opb;
        default:  result = '0;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Result record
  // ----------------------------------------------------------
  // Control fields pass straight through
  assign res_o = '{
    valid:   dec_i.valid,
    illegal: dec_i.illegal,
    wen:     dec_i.wen,
    rd:      dec_i.rd,
    result:  result
  };

endmodule

`default_nettype wire

/* src/rv_writeback.sv */
// ----------------------------------------------------------
// Result stage. Drives the register-file write, the retire
// record and the late bypass
// ----------------------------------------------------------
`default_nettype none

module rv_writeback import rv_pipe_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  exe_res_t res_i,
  output exe_res_t retire_o,
  output logic     rf_we_o,
  output rf_addr_t rf_waddr_o,
  output rf_word_t rf_wdata_o,
  output fwd_t     fwd_late_o
);

  exe_res_t res_q;

  // Result register, invalid out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_q <= '0;
    end else begin
      res_q <= res_i;
    end
  end

  assign retire_o = res_q;

  // Write only for valid results that target x1..x31
  assign rf_we_o    = res_q.valid && res_q.wen;
  assign rf_waddr_o = res_q.rd;
  assign rf_wdata_o = res_q.result;

  // Late bypass mirrors the pending write
  assign fwd_late_o = '{valid: rf_we_o, rd: res_q.rd, value: res_q.result};

endmodule

`default_nettype wire

/* src/rv_int_pipe.sv */
// ----------------------------------------------------------
// Integer pipeline top. Decode, execute, writeback and the
// register file with external load and debug ports
// ----------------------------------------------------------
`default_nettype none

module rv_int_pipe import rv_pipe_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  input  logic        ext_we_i,
  input  rf_addr_t    ext_waddr_i,
  input  rf_word_t    ext_wdata_i,
  input  rf_addr_t    dbg_raddr_i,
  output rf_word_t    dbg_rdata_o,
  output exe_res_t    retire_o
);

  // Two decode read ports plus the debug port
  localparam int unsigned RF_READ_PORTS = 3;

  rf_addr_t rf_raddr [RF_READ_PORTS];
  rf_word_t rf_rdata [RF_READ_PORTS];
  rf_addr_t rf_waddr [REGFILE_NUM_WRITE_PORTS];
  rf_word_t rf_wdata [REGFILE_NUM_WRITE_PORTS];
  logic     rf_we    [REGFILE_NUM_WRITE_PORTS];

  rf_addr_t dec_raddr [2];
  rf_word_t dec_rdata [2];
  dec_op_t  dec_op;
  exe_res_t exe_res;
  fwd_t     fwd_early;
  fwd_t     fwd_late;
  logic     wb_we;
  rf_addr_t wb_waddr;
  rf_word_t wb_wdata;

  // ----------------------------------------------------------
  // Read port map
  // ----------------------------------------------------------
  assign rf_raddr[0]  = dec_raddr[0];
  assign rf_raddr[1]  = dec_raddr[1];
  assign rf_raddr[2]  = dbg_raddr_i;
  assign dec_rdata[0] = rf_rdata[0];
  assign dec_rdata[1] = rf_rdata[1];
  assign dbg_rdata_o  = rf_rdata[2];

  // ----------------------------------------------------------
  // Write port map, external load on the higher priority port
  // ----------------------------------------------------------
  assign rf_we[0]    = wb_we;
  assign rf_waddr[0] = wb_waddr;
  assign rf_wdata[0] = wb_wdata;
  assign rf_we[1]    = ext_we_i;
  assign rf_waddr[1] = ext_waddr_i;
  assign rf_wdata[1] = ext_wdata_i;

  // Early bypass straight from the ALU output
  assign fwd_early = '{valid: exe_res.valid && exe_res.wen, rd: exe_res.rd,
                       value: exe_res.result};

  rv_decode rv_decode_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rf_raddr_o    (dec_raddr),
    .rf_rdata_i    (dec_rdata),
    .fwd_early_i   (fwd_early),
    .fwd_late_i    (fwd_late),
    .dec_o         (dec_op)
  );

  rv_execute rv_execute_inst (
    .dec_i (dec_op),
    .res_o (exe_res)
  );

  rv_writeback rv_writeback_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .res_i      (exe_res),
    .retire_o   (retire_o),
    .rf_we_o    (wb_we),
    .rf_waddr_o (wb_waddr),
    .rf_wdata_o (wb_wdata),
    .fwd_late_o (fwd_late)
  );

  rv_register_file #(
    .NUM_READ_PORTS (RF_READ_PORTS)
  ) rv_register_file_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (rf_raddr),
    .rdata_o (rf_rdata),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .we_i    (rf_we)
  );

endmodule

`default_nettype wire

/* tb/rv_int_pipe_tb.sv */
// ----------------------------------------------------------
// Integer pipeline testbench. Register model, LFSR instruction
// generator and retire checks against an expected queue
// ----------------------------------------------------------
`default_nettype none

module rv_int_pipe_tb import rv_pipe_pkg::*; ();

  // Expected retire record with the cycle it must show up in
  typedef struct packed {
    exe_res_t    res;
    logic [31:0] cyc;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        ext_we_i;
  rf_addr_t    ext_waddr_i;
  rf_word_t    ext_wdata_i;
  rf_addr_t    dbg_raddr_i;
  rf_word_t    dbg_rdata_o;
  exe_res_t    retire_o;

  rf_word_t    model_rf [32];
  expect_t     exp_q [$];
  expect_t     exp_e;
  logic [31:0] cyc = '0;
  logic [31:0] lfsr_q = 32'hd20c;

  rv_int_pipe rv_int_pipe_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .ext_we_i      (ext_we_i),
    .ext_waddr_i   (ext_waddr_i),
    .ext_wdata_i   (ext_wdata_i),
    .dbg_raddr_i   (dbg_raddr_i),
    .dbg_rdata_o   (dbg_rdata_o),
    .retire_o      (retire_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 32'd1;

  // ----------------------------------------------------------
  // Failure reporting
  // ----------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("** Error at time %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, want);
    $display("TB FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("Failure at time %0t: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "run aborted");
  endtask

  // ----------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input rf_addr_t rd, input rf_addr_t rs1,
                                        input rf_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input rf_addr_t rd, input rf_addr_t rs1);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  // Kinds 0..9 register ops, 10..18 immediate ops, 19 LUI, 20..21 illegal
  function automatic logic [31:0] random_instr(input int kind);
    logic [31:0] ins;
    rf_addr_t    rd;
    rf_addr_t    rs1;
    rf_addr_t    rs2;
    logic [11:0] imm;
    logic [6:0]  f7;
    rd  = 5'(rand_bits(5));
    rs1 = 5'(rand_bits(5));
    rs2 = 5'(rand_bits(5));
    imm = 12'(rand_bits(12));
    case (kind)
      0:  ins = enc_r(7'h00, 3'd0, rd, rs1, rs2);
      1:  ins = enc_r(7'h20, 3'd0, rd, rs1, rs2);
      2:  ins = enc_r(7'h00, 3'd1, rd, rs1, rs2);
      3:  ins = enc_r(7'h00, 3'd2, rd, rs1, rs2);
      4:  ins = enc_r(7'h00, 3'd3, rd, rs1, rs2);
      5:  ins = enc_r(7'h00, 3'd4, rd, rs1, rs2);
      6:  ins = enc_r(7'h00, 3'd5, rd, rs1, rs2);
      7:  ins = enc_r(7'h20, 3'd5, rd, rs1, rs2);
      8:  ins = enc_r(7'h00, 3'd6, rd, rs1, rs2);
      9:  ins = enc_r(7'h00, 3'd7, rd, rs1, rs2);
      10: ins = enc_i(imm, 3'd0, rd, rs1);
      11: ins = enc_i(imm, 3'd2, rd, rs1);
      12: ins = enc_i(imm, 3'd3, rd, rs1);
      13: ins = enc_i(imm, 3'd4, rd, rs1);
      14: ins = enc_i(imm, 3'd6, rd, rs1);
      15: ins = enc_i(imm, 3'd7, rd, rs1);
      // Shift immediates carry funct7 above shamt
      16: ins = enc_i({7'h00, imm[4:0]}, 3'd1, rd, rs1);
      17: ins = enc_i({7'h00, imm[4:0]}, 3'd5, rd, rs1);
      18: ins = enc_i({7'h20, imm[4:0]}, 3'd5, rd, rs1);
      19: ins = {20'(rand_bits(20)), rd, OPC_LUI};
      20: begin
        ins = rand_bits(32);
        // Force an opcode outside the supported set
        if (ins[6:0] == OPC_OP || ins[6:0] == OPC_OP_IMM || ins[6:0] == OPC_LUI) begin
          ins[6:0] = 7'b1110011;
        end
      end
      // Bad funct7 on a register op or on a shift immediate
      default: begin
        f7 = 7'(rand_bits(7));
        if (f7 == 7'h00 || f7 == 7'h20) f7[6] = 1'b1;
        if (rand_bits(1) == 32'd0) begin
          ins = enc_r(f7, 3'(rand_bits(3)), rd, rs1, rs2);
        end else begin
          ins = enc_i({f7, imm[4:0]}, (rand_bits(1) == 32'd1) ? 3'd5 : 3'd1, rd, rs1);
        end
      end
    endcase
    return ins;
  endfunction

  // ----------------------------------------------------------
  // Reference model from the RV32I rules
  // ----------------------------------------------------------
  function automatic rf_word_t alu_ref(input logic [2:0] f3, input logic alt,
                                       input rf_word_t a, input rf_word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? rf_word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic exe_res_t predict(input logic [31:0] ins);
    exe_res_t   r;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       alt;
    rf_word_t   a;
    rf_word_t   b;
    f7 = ins[31:25];
    f3 = ins[14:12];
    a  = model_rf[ins[19:15]];
    b  = model_rf[ins[24:20]];
    alt       = f7[5];
    r.valid   = 1'b1;
    r.illegal = 1'b0;
    r.rd      = ins[11:7];
    r.result  = '0;
    case (ins[6:0])
      OPC_OP: begin
        r.illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
      end
      OPC_OP_IMM: begin
        b = {{20{ins[31]}}, ins[31:20]};
        // Only shifts treat the top bits as funct7
        if (f3 == 3'd1) r.illegal = (f7 != 7'h00);
        else if (f3 == 3'd5) r.illegal = !(f7 == 7'h00 || f7 == 7'h20);
        else alt = 1'b0;
      end
      OPC_LUI: r.result = {ins[31:12], 12'h000};
      default: r.illegal = 1'b1;
    endcase
    if (!r.illegal && ins[6:0] != OPC_LUI) r.result = alu_ref(f3, alt, a, b);
    r.wen = !r.illegal && (r.rd != 5'd0);
    return r;
  endfunction

  // ----------------------------------------------------------
  // Drive tasks
  // ----------------------------------------------------------
  // Model moves at issue so later issues see the newest value
  task automatic issue(input logic [31:0] ins);
    expect_t e;
    e.res = predict(ins);
    if (e.res.wen) model_rf[e.res.rd] = e.res.result;
    @(posedge clk);
    // Sampled at the next edge, in writeback one edge later
    e.cyc = cyc + 32'd3;
    exp_q.push_back(e);
    instr_valid_i <= 1'b1;
    instr_i       <= ins;
  endtask

  task automatic idle();
    @(posedge clk);
    instr_valid_i <= 1'b0;
  endtask

  task automatic drain();
    idle();
    for (int n = 0; exp_q.size() != 0; n++) begin
      if (n == 8) abort_run("pipeline did not retire all issued instructions");
      @(posedge clk);
    end
  endtask

  task automatic ext_load(input rf_addr_t addr, input rf_word_t data);
    @(posedge clk);
    ext_we_i    <= 1'b1;
    ext_waddr_i <= addr;
    ext_wdata_i <= data;
    @(posedge clk);
    ext_we_i <= 1'b0;
    // x0 keeps reading zero on the decode side
    if (addr != 5'd0) model_rf[addr] = data;
  endtask

  task automatic check_debug(input rf_addr_t addr, input rf_word_t want);
    @(posedge clk);
    dbg_raddr_i <= addr;
    @(negedge clk);
    assert (dbg_rdata_o == want) else report_mismatch("dbg_rdata_o", dbg_rdata_o, want);
  endtask

  // ----------------------------------------------------------
  // Retire checker, mid-cycle where outputs are settled
  // ----------------------------------------------------------
  always @(negedge clk) begin
    if (retire_o.valid) begin
      if (exp_q.size() == 0) begin
        abort_run("retire_o.valid went high with no instruction in flight");
      end else begin
        exp_e = exp_q.pop_front();
        assert (cyc == exp_e.cyc) else report_mismatch("retire cycle", cyc, exp_e.cyc);
        assert (retire_o.illegal == exp_e.res.illegal)
          else report_mismatch("retire_o.illegal", 32'(retire_o.illegal),
                               32'(exp_e.res.illegal));
        assert (retire_o.wen == exp_e.res.wen)
          else report_mismatch("retire_o.wen", 32'(retire_o.wen), 32'(exp_e.res.wen));
        assert (retire_o.rd == exp_e.res.rd)
          else report_mismatch("retire_o.rd", 32'(retire_o.rd), 32'(exp_e.res.rd));
        assert (retire_o.result == exp_e.res.result)
          else report_mismatch("retire_o.result", retire_o.result, exp_e.res.result);
      end
    end
  end

  // Cycle limit for the whole run
  initial begin
    repeat (50000) @(posedge clk);
    abort_run("simulation exceeded its cycle limit");
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    int kind;
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    ext_we_i      = 1'b0;
    ext_waddr_i   = '0;
    ext_wdata_i   = '0;
    dbg_raddr_i   = '0;
    for (int r = 0; r < 32; r++) model_rf[r] = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Registers come out of reset cleared
    for (int r = 0; r < 32; r++) check_debug(5'(r), '0);

    // External loads read back on the debug port
    for (int r = 1; r < 32; r++) ext_load(5'(r), rand_bits(32));
    for (int r = 1; r < 32; r++) check_debug(5'(r), model_rf[r]);

    // Load into x0 is invisible to decode operands
    ext_load(5'd0, 32'h5a5a_0001);
    issue(enc_r(7'h00, 3'd0, 5'd13, 5'd0, 5'd1));
    drain();
    ext_load(5'd0, '0);

    // Producer then consumers at distance 1, 2 and 3
    issue(enc_i(12'h123, 3'd0, 5'd7, 5'd1));
    issue(enc_r(7'h00, 3'd0, 5'd8, 5'd7, 5'd2));
    issue(enc_r(7'h20, 3'd0, 5'd9, 5'd2, 5'd7));
    issue(enc_r(7'h00, 3'd6, 5'd10, 5'd7, 5'd8));
    // Early bypass beats late for the same rd
    issue(enc_i(12'h001, 3'd0, 5'd11, 5'd0));
    issue(enc_i(12'h002, 3'd0, 5'd11, 5'd0));
    issue(enc_r(7'h00, 3'd0, 5'd12, 5'd11, 5'd11));
    // Writes to x0 retire without effect
    issue(enc_i(12'h055, 3'd0, 5'd0, 5'd1));
    issue(enc_r(7'h00, 3'd0, 5'd14, 5'd0, 5'd0));
    drain();
    check_debug(5'd0, '0);

    // Random run, each kind once first, with random bubbles
    for (int i = 0; i < 600; i++) begin
      kind = (i < 22) ? i : int'(rand_bits(5) % 32'd22);
      issue(random_instr(kind));
      if (rand_bits(2) == 32'd0) idle();
    end
    drain();

    // Final register dump against the model
    for (int r = 0; r < 32; r++) check_debug(5'(r), model_rf[r]);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* rv_int_pipe.f */
src/rv_pipe_pkg.sv
src/rv_register_file.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_writeback.sv
src/rv_int_pipe.sv
tb/rv_int_pipe_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the integer pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module rv_int_pipe_tb \
  --Mdir obj_dir \
  -f rv_int_pipe.f

# A failing check ends in $fatal, which gives a nonzero exit status
./obj_dir/Vrv_int_pipe_tb
